//--- Makefile
TOOL      = verilator
FLAGS     = --binary --timing
TOP       = tb_flash_writer
FILE_LIST = verilog.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "Simulation FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- source/apb_flash_regs.sv
`timescale 1ns/1ps

module apb_flash_regs (
   input  logic                                   clk,
   input  logic                                   reset,
   input  logic                                   psel,
   input  logic                                   penable,
   input  logic                                   pwrite,
   input  logic [3:0]                             paddr,
   input  logic [31:0]                            pwdata,
   output logic [31:0]                            prdata,
   output logic                                   pready,
   output logic                                   pslverr,
   input  logic                                   busy,
   input  logic                                   cmd_take,
   output logic                                   start_valid,
   output logic [flash_pkg::FLASH_ADDR_WIDTH-1:0] start_addr,
   output flash_pkg::write_cmd_t                  write_cmd
);

   logic        slot_full;
   logic [15:0] slot_data;
   logic        finish_req;
   logic        access;
   logic        data_stall;
   logic        session;
   logic        wr_accept;

   assign access     = psel && penable;
   assign data_stall = pwrite && (paddr == flash_pkg::REG_DATA) && slot_full;
   assign pready     = access && !data_stall; // only data writes see wait states
   assign session    = busy || start_valid; // start_valid covers the cycle before busy rises
   assign pslverr    = access && pwrite && (paddr == flash_pkg::REG_ADDR) && session;
   assign wr_accept  = pready && pwrite;

   assign write_cmd.halfword   = slot_data;
   assign write_cmd.data_valid = slot_full;
   assign write_cmd.finish     = finish_req;

   always_comb begin
      prdata = '0;
      if (psel && !pwrite) begin
         case (paddr)
            flash_pkg::REG_ADDR:   prdata = 32'(start_addr);
            flash_pkg::REG_CTRL:   prdata = {31'h0, finish_req};
            flash_pkg::REG_STATUS: prdata = {30'h0, !slot_full, busy};
            default:               prdata = '0;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (wr_accept && paddr == flash_pkg::REG_DATA)
         slot_data <= pwdata[15:0];
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         start_valid <= 1'b0;
         start_addr  <= '0;
         slot_full   <= 1'b0;
         finish_req  <= 1'b0;
      end else begin
         start_valid <= 1'b0;

         // refused address writes are dropped
         if (wr_accept && paddr == flash_pkg::REG_ADDR && !session) begin
            start_addr  <= pwdata[flash_pkg::FLASH_ADDR_WIDTH-1:0];
            start_valid <= 1'b1;
         end

         // take clears data first, finish only once the slot is empty
         if (cmd_take) begin
            if (slot_full)
               slot_full <= 1'b0;
            else
               finish_req <= 1'b0;
         end

         if (wr_accept && paddr == flash_pkg::REG_DATA)
            slot_full <= 1'b1;

         // finish outside a session would stall the next one
         if (wr_accept && paddr == flash_pkg::REG_CTRL && pwdata[0] && session)
            finish_req <= 1'b1;
      end
   end

endmodule

//--- source/flash_page_writer.sv
`timescale 1ns/1ps

module flash_page_writer (
   input  logic                                   clk,
   input  logic                                   reset,
   input  logic                                   start_valid,
   input  logic [flash_pkg::FLASH_ADDR_WIDTH-1:0] start_addr,
   input  flash_pkg::write_cmd_t                  write_cmd,
   output logic                                   cmd_take,
   output logic                                   busy,
   output flash_pkg::spi_byte_t                   byte_out,
   output logic                                   byte_valid,
   input  logic                                   byte_ready
);

   flash_pkg::writer_state_e                   state;
   logic [flash_pkg::FLASH_ADDR_WIDTH-1:0]     page_addr;
   logic [15:0]                                data_reg;
   logic [7:0]                                 hold_byte;
   logic                                       addr_index;
   logic [flash_pkg::HALFWORD_COUNT_WIDTH-1:0] halfword_count;
   logic [flash_pkg::SETTLE_COUNT_WIDTH-1:0]   settle_count;
   logic                                       page_full;
   logic                                       accept;
   logic                                       gap_done;
   logic                                       in_wait;

   assign page_full = (halfword_count == flash_pkg::PAGE_FULL_COUNT);
   assign accept    = byte_valid && byte_ready;
   assign gap_done  = (settle_count == flash_pkg::GAP_LAST_COUNT);
   assign busy      = (state != flash_pkg::IDLE);
   assign in_wait   = (state == flash_pkg::WAKE_WAIT) || (state == flash_pkg::WE_WAIT) ||
                      (state == flash_pkg::BANK_WAIT);

   // slot is consumed when the held byte goes out, data wins over finish
   assign cmd_take = (state == flash_pkg::DATA_WAIT) && accept && !page_full;

   // The byte ahead of a halfword boundary is held back until the next
   // slot content is known, so it can carry the last flag on a finish.
   always_comb begin
      byte_valid    = 1'b0;
      byte_out.data = hold_byte;
      byte_out.last = 1'b0;
      case (state)
         flash_pkg::WAKE_UP: begin
            byte_valid    = 1'b1;
            byte_out.data = flash_pkg::OP_WAKE_UP;
            byte_out.last = 1'b1;
         end
         flash_pkg::WRITE_ENABLE: begin
            byte_valid    = 1'b1;
            byte_out.data = flash_pkg::OP_WRITE_ENABLE;
            byte_out.last = 1'b1;
         end
         flash_pkg::PROGRAM_CMD: begin
            byte_valid    = 1'b1;
            byte_out.data = flash_pkg::OP_PAGE_PROGRAM;
         end
         flash_pkg::PROGRAM_ADDR: begin
            byte_valid    = 1'b1;
            byte_out.data = addr_index ? page_addr[15:8] : page_addr[23:16];
         end
         flash_pkg::DATA_SEND: begin
            byte_valid    = 1'b1;
            byte_out.data = data_reg[15:8]; // high byte first
         end
         flash_pkg::DATA_WAIT: begin
            byte_valid    = page_full || write_cmd.data_valid || write_cmd.finish;
            byte_out.last = page_full || !write_cmd.data_valid;
         end
         default: begin
         end
      endcase
   end

   // payload
   always_ff @(posedge clk) begin
      if (state == flash_pkg::IDLE && start_valid)
         page_addr <= start_addr;
      else if (state == flash_pkg::DATA_WAIT && accept && page_full)
         page_addr <= page_addr + flash_pkg::PAGE_ADDR_STEP;

      if (state == flash_pkg::PROGRAM_ADDR && accept && addr_index)
         hold_byte <= page_addr[7:0];
      else if (state == flash_pkg::DATA_SEND && accept)
         hold_byte <= data_reg[7:0];

      if (cmd_take && write_cmd.data_valid)
         data_reg <= write_cmd.halfword;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state          <= flash_pkg::IDLE;
         addr_index     <= 1'b0;
         halfword_count <= '0;
         settle_count   <= '0;
      end else begin
         // settle counter only runs in the three waits
         if (in_wait)
            settle_count <= settle_count + 1'b1;
         else
            settle_count <= '0;

         case (state)
            flash_pkg::IDLE:
               if (start_valid) state <= flash_pkg::WAKE_UP;
            flash_pkg::WAKE_UP:
               if (accept) state <= flash_pkg::WAKE_WAIT;
            flash_pkg::WAKE_WAIT:
               if (gap_done) state <= flash_pkg::WRITE_ENABLE;
            flash_pkg::WRITE_ENABLE:
               if (accept) state <= flash_pkg::WE_WAIT;
            flash_pkg::WE_WAIT:
               if (gap_done) state <= flash_pkg::PROGRAM_CMD;
            flash_pkg::PROGRAM_CMD: begin
               addr_index <= 1'b0;
               if (accept) state <= flash_pkg::PROGRAM_ADDR;
            end
            flash_pkg::PROGRAM_ADDR: begin
               if (accept) begin
                  addr_index <= 1'b1;
                  if (addr_index) begin // low address byte is held
                     halfword_count <= '0;
                     state          <= flash_pkg::DATA_WAIT;
                  end
               end
            end
            flash_pkg::DATA_WAIT: begin
               if (accept) begin
                  if (page_full) begin
                     state <= flash_pkg::BANK_WAIT;
                  end else if (write_cmd.data_valid) begin
                     halfword_count <= halfword_count + 1'b1;
                     state          <= flash_pkg::DATA_SEND;
                  end else begin
                     state <= flash_pkg::IDLE; // finish closes the frame
                  end
               end
            end
            flash_pkg::DATA_SEND:
               if (accept) state <= flash_pkg::DATA_WAIT;
            flash_pkg::BANK_WAIT:
               if (gap_done) state <= flash_pkg::WRITE_ENABLE; // no wake-up on next page
            default:
               state <= flash_pkg::IDLE;
         endcase
      end
   end

endmodule

//--- source/flash_pkg.sv
package flash_pkg;

   // flash opcodes
   typedef enum logic [7:0] {
      OP_WAKE_UP      = 8'hAB, // release from deep power-down
      OP_WRITE_ENABLE = 8'h06,
      OP_PAGE_PROGRAM = 8'h02
   } opcode_e;

   typedef enum logic [3:0] {
      IDLE,
      WAKE_UP,
      WAKE_WAIT,
      WRITE_ENABLE,
      WE_WAIT,
      PROGRAM_CMD,
      PROGRAM_ADDR,
      DATA_WAIT,
      DATA_SEND,
      BANK_WAIT
   } writer_state_e;

   // spi bit timing
   localparam int CLKS_PER_BIT    = 8;
   localparam int CLK_COUNT_WIDTH = $clog2(CLKS_PER_BIT);
   localparam logic [CLK_COUNT_WIDTH-1:0] SCK_RISE_COUNT = CLK_COUNT_WIDTH'(4);
   localparam logic [CLK_COUNT_WIDTH-1:0] LAST_CLK_COUNT = CLK_COUNT_WIDTH'(CLKS_PER_BIT - 1);

   // slave select high time between frames in place of status polling
   localparam int SETTLE_CYCLES = 64;
   // counted from the accept of a frame's last byte, which still has to shift out
   localparam int FRAME_GAP_CYCLES   = CLKS_PER_BIT * 8 + SETTLE_CYCLES;
   localparam int SETTLE_COUNT_WIDTH = $clog2(FRAME_GAP_CYCLES);
   localparam logic [SETTLE_COUNT_WIDTH-1:0] GAP_LAST_COUNT =
      SETTLE_COUNT_WIDTH'(FRAME_GAP_CYCLES - 1);

   localparam int PAGE_HALFWORDS       = 8;
   localparam int HALFWORD_COUNT_WIDTH = $clog2(PAGE_HALFWORDS + 1);
   localparam logic [HALFWORD_COUNT_WIDTH-1:0] PAGE_FULL_COUNT =
      HALFWORD_COUNT_WIDTH'(PAGE_HALFWORDS);

   localparam int FLASH_ADDR_WIDTH = 24;
   localparam logic [FLASH_ADDR_WIDTH-1:0] PAGE_ADDR_STEP =
      FLASH_ADDR_WIDTH'(2 * PAGE_HALFWORDS); // byte address step per page

   // apb register offsets
   localparam logic [3:0] REG_ADDR   = 4'h0;
   localparam logic [3:0] REG_DATA   = 4'h4;
   localparam logic [3:0] REG_CTRL   = 4'h8;
   localparam logic [3:0] REG_STATUS = 4'hC;

   typedef struct packed {
      logic [7:0] data;
      logic       last; // release slave select after this byte
   } spi_byte_t;

   typedef struct packed {
      logic [15:0] halfword;
      logic        data_valid;
      logic        finish;
   } write_cmd_t;

endpackage

//--- source/flash_writer_top.sv
`timescale 1ns/1ps

module flash_writer_top (
   input  logic        clk,
   input  logic        reset,
   input  logic        psel,
   input  logic        penable,
   input  logic        pwrite,
   input  logic [3:0]  paddr,
   input  logic [31:0] pwdata,
   output logic [31:0] prdata,
   output logic        pready,
   output logic        pslverr,
   output logic        spi_sck,
   output logic        spi_ss,
   output logic        spi_mosi
);

   logic                                   busy;
   logic                                   cmd_take;
   logic                                   start_valid;
   logic [flash_pkg::FLASH_ADDR_WIDTH-1:0] start_addr;
   flash_pkg::write_cmd_t                  write_cmd;
   flash_pkg::spi_byte_t                   byte_bus;
   logic                                   byte_valid;
   logic                                   byte_ready;

   apb_flash_regs u_regs (
      .clk         (clk),
      .reset       (reset),
      .psel        (psel),
      .penable     (penable),
      .pwrite      (pwrite),
      .paddr       (paddr),
      .pwdata      (pwdata),
      .prdata      (prdata),
      .pready      (pready),
      .pslverr     (pslverr),
      .busy        (busy),
      .cmd_take    (cmd_take),
      .start_valid (start_valid),
      .start_addr  (start_addr),
      .write_cmd   (write_cmd)
   );

   flash_page_writer u_writer (
      .clk         (clk),
      .reset       (reset),
      .start_valid (start_valid),
      .start_addr  (start_addr),
      .write_cmd   (write_cmd),
      .cmd_take    (cmd_take),
      .busy        (busy),
      .byte_out    (byte_bus),
      .byte_valid  (byte_valid),
      .byte_ready  (byte_ready)
   );

   spi_byte_shifter u_shifter (
      .clk        (clk),
      .reset      (reset),
      .byte_in    (byte_bus),
      .byte_valid (byte_valid),
      .byte_ready (byte_ready),
      .spi_sck    (spi_sck),
      .spi_ss     (spi_ss),
      .spi_mosi   (spi_mosi)
   );

endmodule

//--- source/spi_byte_shifter.sv
`timescale 1ns/1ps

module spi_byte_shifter (
   input  logic                 clk,
   input  logic                 reset,
   input  flash_pkg::spi_byte_t byte_in,
   input  logic                 byte_valid,
   output logic                 byte_ready,
   output logic                 spi_sck,
   output logic                 spi_ss,
   output logic                 spi_mosi
);

   logic [7:0]                            shift_reg;
   logic                                  last_byte;
   logic                                  active;
   logic                                  release_pending;
   logic [flash_pkg::CLK_COUNT_WIDTH-1:0] clk_count;
   logic [2:0]                            bit_count;
   logic                                  byte_end;
   logic                                  accept;

   // last clock of the last bit
   assign byte_end   = active && (clk_count == flash_pkg::LAST_CLK_COUNT) && (bit_count == 3'd7);
   assign byte_ready = !active || byte_end; // keeps bytes of one frame back to back
   assign accept     = byte_valid && byte_ready;

   always_ff @(posedge clk) begin
      if (accept) begin
         shift_reg <= byte_in.data;
         last_byte <= byte_in.last;
      end else if (active && clk_count == flash_pkg::LAST_CLK_COUNT) begin
         shift_reg <= {shift_reg[6:0], 1'b0}; // msb first
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         active          <= 1'b0;
         release_pending <= 1'b0;
         clk_count       <= '0;
         bit_count       <= '0;
         spi_sck         <= 1'b0;
         spi_ss          <= 1'b1;
         spi_mosi        <= 1'b0;
      end else begin
         if (accept) begin
            active          <= 1'b1;
            release_pending <= 1'b0;
            clk_count       <= '0;
            bit_count       <= '0;
            spi_ss          <= 1'b0;
         end else if (byte_end) begin
            active          <= 1'b0;
            release_pending <= last_byte;
         end else if (active) begin
            clk_count <= clk_count + 1'b1;
            if (clk_count == flash_pkg::LAST_CLK_COUNT)
               bit_count <= bit_count + 1'b1;
         end else if (release_pending) begin
            spi_ss          <= 1'b1; // one clock after the final bit
            release_pending <= 1'b0;
         end

         // mode 0 timing inside a bit
         if (active) begin
            if (clk_count == '0) begin
               spi_mosi <= shift_reg[7];
               spi_sck  <= 1'b0;
            end else if (clk_count == flash_pkg::SCK_RISE_COUNT) begin
               spi_sck <= 1'b1;
            end
         end else begin
            spi_sck <= 1'b0; // idle or stalled mid frame
         end
      end
   end

endmodule

//--- test/flash_spi_checker.sv
`timescale 1ns/1ps

module flash_spi_checker (
   input logic        clk,
   input logic        reset,
   input logic        psel,
   input logic        penable,
   input logic        pwrite,
   input logic [3:0]  paddr,
   input logic [31:0] prdata,
   input logic        pready,
   input logic        pslverr,
   input logic        spi_sck,
   input logic        spi_ss,
   input logic        spi_mosi
);

   typedef struct packed {
      logic        check_rdata;
      logic [31:0] rdata;
      logic        pslverr;
   } apb_expect_t;

   logic [7:0]  exp_bytes[$];
   int          exp_lengths[$];
   apb_expect_t exp_apb[$];
   logic [7:0]  got_bytes[$];
   logic [7:0]  shift_byte;
   int          building_len;
   int          bit_count;
   logic        sck_q;
   logic        ss_q;
   logic        seen_transfer;
   int          frames_seen;
   int          spi_errors;
   int          apb_errors;
   int          protocol_errors;

   initial begin
      building_len    = 0;
      bit_count       = 0;
      sck_q           = 1'b0;
      ss_q            = 1'b1;
      seen_transfer   = 1'b0;
      frames_seen     = 0;
      spi_errors      = 0;
      apb_errors      = 0;
      protocol_errors = 0;
   end

   task automatic push_expected_byte(input logic [7:0] value);
      exp_bytes.push_back(value);
      building_len++;
   endtask

   task automatic end_expected_frame();
      exp_lengths.push_back(building_len);
      building_len = 0;
   endtask

   task automatic expect_apb(input logic check_rdata, input logic [31:0] rdata,
                             input logic err);
      exp_apb.push_back({check_rdata, rdata, err});
   endtask

   task automatic check_reset_value(input string name, input logic expected,
                                    input logic actual);
      if (actual !== expected) begin
         $display("[FAIL] %s before the first transfer: expected 0x%0h, got 0x%0h",
                  name, expected, actual);
         protocol_errors++;
      end
   endtask

   task automatic check_frame();
      int         expected_len;
      logic [7:0] expected;
      int         i;
      frames_seen++;
      if (bit_count != 0) begin
         $display("frame %0d ended %0d bits into a byte", frames_seen, bit_count);
         protocol_errors++;
      end
      if (exp_lengths.size() == 0) begin
         $display("extra SPI frame %0d of %0d bytes, no frame was expected",
                  frames_seen, got_bytes.size());
         protocol_errors++;
      end else begin
         expected_len = exp_lengths.pop_front();
         if (expected_len != got_bytes.size()) begin
            $display("frame %0d has %0d bytes where %0d were expected",
                     frames_seen, got_bytes.size(), expected_len);
            protocol_errors++;
         end
         for (i = 0; i < expected_len; i++) begin
            expected = exp_bytes.pop_front();
            if (i < got_bytes.size() && got_bytes[i] !== expected) begin
               $display("[FAIL] spi_mosi frame %0d byte %0d: expected 0x%02h, got 0x%02h",
                        frames_seen, i, expected, got_bytes[i]);
               spi_errors++;
            end
         end
      end
   endtask

   task automatic check_apb_response();
      apb_expect_t e;
      if (exp_apb.size() == 0) begin
         $display("APB transfer at 0x%0h completed with no response expected", paddr);
         protocol_errors++;
         return;
      end
      e = exp_apb.pop_front();
      if (pslverr !== e.pslverr) begin
         $display("[FAIL] pslverr at 0x%0h: expected 0x%0h, got 0x%0h",
                  paddr, e.pslverr, pslverr);
         apb_errors++;
      end
      if (e.check_rdata && !pwrite && prdata !== e.rdata) begin
         $display("[FAIL] prdata at 0x%0h: expected 0x%08h, got 0x%08h",
                  paddr, e.rdata, prdata);
         apb_errors++;
      end
   endtask

   // DUT outputs change on the rising edge and are sampled mid-cycle
   always @(negedge clk) begin
      if (reset) begin
         sck_q     = 1'b0;
         ss_q      = 1'b1;
         bit_count = 0;
      end else begin
         if (!seen_transfer) begin
            check_reset_value("spi_ss", 1'b1, spi_ss);
            check_reset_value("spi_sck", 1'b0, spi_sck);
            check_reset_value("spi_mosi", 1'b0, spi_mosi);
            check_reset_value("pready", 1'b0, pready);
            check_reset_value("pslverr", 1'b0, pslverr);
         end
         if (psel)
            seen_transfer = 1'b1;
         if (spi_ss && spi_sck) begin
            $display("SCK is high while slave select is released");
            protocol_errors++;
         end
         if (ss_q && !spi_ss) begin // frame opens
            got_bytes.delete();
            bit_count = 0;
         end
         if (!spi_ss && spi_sck && !sck_q) begin
            shift_byte = {shift_byte[6:0], spi_mosi}; // msb arrives first
            bit_count++;
            if (bit_count == 8) begin
               got_bytes.push_back(shift_byte);
               bit_count = 0;
            end
         end
         if (!ss_q && spi_ss)
            check_frame();
         if (psel && penable && pready)
            check_apb_response();
         sck_q = spi_sck;
         ss_q  = spi_ss;
      end
   end

endmodule

//--- test/flash_write_trace.txt
# W <paddr> <pwdata> <pslverr>   apb write, R <paddr> <prdata>   apb read
# E <bytes on mosi>   one frame   G <0|1> idle gaps   Q wait for listed frames
# status after reset, idle with the slot free
R 0C 00000002
# session one, then a refused address write while busy
W 00 00012340 0
W 00 00FFFFF0 1
R 00 00012340
# back to back data writes, stalled by pready
G 0
W 04 0000A1B2 0
W 04 0000C3D4 0
W 04 0000E5F6 0
G 1
W 08 00000001 0
E AB
E 06
E 02 01 23 40 A1 B2 C3 D4 E5 F6
Q
R 0C 00000002
# session two, eleven halfwords across a page boundary
W 00 003C0010 0
W 04 00001357 0
W 04 00002468 0
W 04 00009ACE 0
W 04 0000BDF0 0
W 04 00000F1E 0
W 04 00002D3C 0
W 04 00004B5A 0
W 04 00006978 0
W 04 00008796 0
W 04 0000A5B4 0
W 04 0000C3D2 0
W 08 00000001 0
E AB
E 06
E 02 3C 00 10 13 57 24 68 9A CE BD F0 0F 1E 2D 3C 4B 5A 69 78
E 06
E 02 3C 00 20 87 96 A5 B4 C3 D2
Q
R 0C 00000002

//--- test/tb_flash_writer.sv
`timescale 1ns/1ps

module tb_flash_writer;

   localparam int          CLK_HALF_NS     = 2;
   localparam int          RESET_CYCLES    = 8;
   localparam int          BYTE_CLOCKS     = 64;     // 8 bits of 8 clocks
   localparam int          FRAME_ALLOWANCE = 3 * 64; // three settle waits per frame
   localparam int          TIMEOUT_MARGIN  = 1000;
   localparam logic [31:0] SEED            = 32'h22a2_837c;
   localparam string       TRACE_FILE      = "test/flash_write_trace.txt";

   logic        clk;
   logic        reset;
   logic        psel;
   logic        penable;
   logic        pwrite;
   logic [3:0]  paddr;
   logic [31:0] pwdata;
   logic [31:0] prdata;
   logic        pready;
   logic        pslverr;
   logic        spi_sck;
   logic        spi_ss;
   logic        spi_mosi;

   string       trace_lines[$];
   int          total_bytes;
   int          total_frames;
   int          frames_listed;
   int          cycle_count;
   int          timeout_limit;
   int          tb_errors;
   int          error_total;
   logic [31:0] rand_state;
   logic        gaps_on;

   flash_writer_top dut (.*);

   flash_spi_checker u_checker (.*);

   always #CLK_HALF_NS clk = ~clk;

   // run limit is set from the expected frames before reset ends
   always @(posedge clk) begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= timeout_limit) begin
         $display("timeout: the run did not end within %0d cycles", timeout_limit);
         $display("Simulation FAILED");
         $finish;
      end
   end

   function automatic logic [31:0] next_random(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic int hex_value(input logic [7:0] c);
      if (c >= 8'h30 && c <= 8'h39)
         return int'(c - 8'h30);
      if (c >= 8'h61 && c <= 8'h66)
         return int'(c - 8'h61) + 10;
      if (c >= 8'h41 && c <= 8'h46)
         return int'(c - 8'h41) + 10;
      return -1;
   endfunction

   task automatic read_trace();
      int    fd;
      string line;
      fd = $fopen(TRACE_FILE, "r");
      if (fd == 0) begin
         $display("cannot open the trace file %s", TRACE_FILE);
         tb_errors++;
         return;
      end
      while (!$feof(fd)) begin
         line = "";
         if ($fgets(line, fd) > 0)
            trace_lines.push_back(line);
      end
      $fclose(fd);
   endtask

   // hands one E line to the checker, byte by byte
   task automatic queue_expected_frame(input string line);
      logic [7:0] value;
      logic [7:0] c;
      logic       in_token;
      int         d;
      int         i;
      value    = 8'h00;
      in_token = 1'b0;
      for (i = 1; i <= line.len(); i++) begin
         c = (i < line.len()) ? line.getc(i) : 8'h20;
         d = hex_value(c);
         if (d >= 0) begin
            value    = {value[3:0], d[3:0]};
            in_token = 1'b1;
         end else if (in_token) begin
            u_checker.push_expected_byte(value);
            total_bytes++;
            value    = 8'h00;
            in_token = 1'b0;
         end
      end
      u_checker.end_expected_frame();
      total_frames++;
   endtask

   // starts and ends 1 ns after a rising edge
   task automatic apb_transfer(input logic write, input logic [3:0] addr,
                               input logic [31:0] data);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = write;
      paddr   = addr;
      pwdata  = data;
      @(posedge clk);
      #1;
      penable = 1'b1;
      @(negedge clk);
      while (!pready)
         @(negedge clk);
      @(posedge clk);
      #1;
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic insert_idle_cycles();
      int n;
      rand_state = next_random(rand_state);
      n = gaps_on ? int'(rand_state[1:0]) : 0;
      repeat (n) begin
         @(posedge clk);
         #1;
      end
   endtask

   task automatic wait_for_frames();
      while (u_checker.frames_seen < frames_listed) begin
         @(posedge clk);
         #1;
      end
   endtask

   task automatic run_trace();
      string       line;
      logic [7:0]  kind;
      logic [31:0] addr;
      logic [31:0] data;
      logic [31:0] flag;
      foreach (trace_lines[n]) begin
         line = trace_lines[n];
         kind = line.getc(0);
         case (kind)
            "W": begin
               if ($sscanf(line, "W %h %h %h", addr, data, flag) != 3) begin
                  $display("unreadable trace line: %s", line);
                  tb_errors++;
               end else begin
                  u_checker.expect_apb(1'b0, 32'h0, flag[0]);
                  apb_transfer(1'b1, addr[3:0], data);
                  insert_idle_cycles();
               end
            end
            "R": begin
               if ($sscanf(line, "R %h %h", addr, data) != 2) begin
                  $display("unreadable trace line: %s", line);
                  tb_errors++;
               end else begin
                  u_checker.expect_apb(1'b1, data, 1'b0);
                  apb_transfer(1'b0, addr[3:0], 32'h0);
                  insert_idle_cycles();
               end
            end
            "G": if ($sscanf(line, "G %h", flag) == 1) gaps_on = flag[0];
            "E": frames_listed++;
            "Q": wait_for_frames();
            default: begin
            end
         endcase
      end
   endtask

   initial begin
      clk           = 1'b0;
      reset         = 1'b1;
      psel          = 1'b0;
      penable       = 1'b0;
      pwrite        = 1'b0;
      paddr         = 4'h0;
      pwdata        = 32'h0;
      cycle_count   = 0;
      tb_errors     = 0;
      total_bytes   = 0;
      total_frames  = 0;
      frames_listed = 0;
      gaps_on       = 1'b1;
      rand_state    = SEED;
      timeout_limit = TIMEOUT_MARGIN;

      read_trace();
      foreach (trace_lines[n])
         if (trace_lines[n].getc(0) == "E")
            queue_expected_frame(trace_lines[n]);
      timeout_limit = total_bytes * BYTE_CLOCKS + total_frames * FRAME_ALLOWANCE +
                      TIMEOUT_MARGIN;

      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      reset = 1'b0;

      run_trace();
      wait_for_frames();
      if (u_checker.frames_seen != total_frames) begin
         $display("saw %0d SPI frames, the trace lists %0d", u_checker.frames_seen,
                  total_frames);
         tb_errors++;
      end

      error_total = u_checker.spi_errors + u_checker.apb_errors +
                    u_checker.protocol_errors + tb_errors;
      $display("errors: spi %0d, apb %0d, protocol %0d, testbench %0d",
               u_checker.spi_errors, u_checker.apb_errors, u_checker.protocol_errors,
               tb_errors);
      if (error_total == 0)
         $display("Simulation PASSED");
      else
         $display("Simulation FAILED");
      $finish;
   end

endmodule

//--- verilog.f
source/flash_pkg.sv
source/spi_byte_shifter.sv
source/flash_page_writer.sv
source/apb_flash_regs.sv
source/flash_writer_top.sv
test/flash_spi_checker.sv
test/tb_flash_writer.sv
